// File: hw/mlx_defs.svh
`ifndef MLX_DEFS_SVH
`define MLX_DEFS_SVH

// ------------------------------------------------
// sensor frame geometry
// ------------------------------------------------

// 32 x 24 pixels per frame
`define MLX_PIXELS 768
`define MLX_ADDR_W 10

// ------------------------------------------------
// datapath widths
// ------------------------------------------------

// raw and corrected pixel, signed
`define MLX_RAW_W 16
// one bit wider than raw so max - min never overflows
`define MLX_RANGE_W 17

// display output
`define MLX_NORM_W 8
`define MLX_NORM_MAX 255

// quotient bits produced by the serial divider
`define MLX_DIV_STEPS 8

`endif

// File: hw/mlx_pixel_pkg.sv
`default_nettype none

`include "mlx_defs.svh"

package mlx_pixel_pkg;

    // index into the 32x24 frame
    typedef logic [`MLX_ADDR_W-1:0] pix_addr_t;

    // raw sensor word, also used after offset correction
    typedef logic signed [`MLX_RAW_W-1:0] raw_pix_t;

    // calibration word
    // top bit flags a dead pixel, lower bits hold a signed offset
    typedef logic [`MLX_RAW_W-1:0] cal_word_t;

    // max - min over one frame and never zero
    typedef logic [`MLX_RANGE_W-1:0] range_t;

    // display value 0..255
    typedef logic [`MLX_NORM_W-1:0] norm_pix_t;

endpackage

`default_nettype wire

// File: hw/mlx_ctrl_pkg.sv
`default_nettype none

`include "mlx_defs.svh"

package mlx_ctrl_pkg;

    // normalizer sequence per pixel
    // FETCH issues the raw read, DIVIDE loads then runs the quotient bits,
    // STORE writes the display pixel
    typedef enum logic [1:0] {
        IDLE,
        FETCH,
        DIVIDE,
        STORE
    } norm_state_t;

endpackage

`default_nettype wire

// File: hw/frame_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "mlx_defs.svh"

module frame_ram #(
    parameter int DATA_W = `MLX_RAW_W
) (
    input  logic                     i_clk,
    input  logic                     i_we,
    input  mlx_pixel_pkg::pix_addr_t i_waddr,
    input  logic [DATA_W-1:0]        i_wdata,
    input  logic                     i_re,
    input  mlx_pixel_pkg::pix_addr_t i_raddr,
    output logic [DATA_W-1:0]        o_rdata
);

    // one entry per pixel
    logic [DATA_W-1:0] mem [0:`MLX_PIXELS-1];

    always_ff @(posedge i_clk) begin
        if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
        // registered read with data one cycle after i_re
        if (i_re) begin
            o_rdata <= mem[i_raddr];
        end
    end

endmodule

`default_nettype wire

// File: hw/offset_correct.sv
`timescale 1ns/1ps
`default_nettype none

`include "mlx_defs.svh"

module offset_correct (
    input  logic                      i_clk,
    input  logic                      i_rst,
    // calibration table load
    input  logic                      i_cal_we,
    input  mlx_pixel_pkg::pix_addr_t  i_cal_addr,
    input  mlx_pixel_pkg::cal_word_t  i_cal_data,
    // raw pixel strobe
    input  logic                      i_pix_valid,
    input  mlx_pixel_pkg::pix_addr_t  i_pix_addr,
    input  mlx_pixel_pkg::raw_pix_t   i_pix_data,
    // corrected pixel strobe two cycles later
    output logic                      o_corr_valid,
    output mlx_pixel_pkg::pix_addr_t  o_corr_addr,
    output mlx_pixel_pkg::raw_pix_t   o_corr_data,
    output logic                      o_corr_dead
);

    mlx_pixel_pkg::cal_word_t cal_rd;

    logic                     pix_valid_q;
    mlx_pixel_pkg::pix_addr_t pix_addr_q;
    mlx_pixel_pkg::raw_pix_t  pix_data_q;

    mlx_pixel_pkg::raw_pix_t  offset;
    mlx_pixel_pkg::raw_pix_t  corrected;
    logic                     dead;
    mlx_pixel_pkg::raw_pix_t  last_good;

    // ------------------------------------------------
    // calibration table
    // ------------------------------------------------
    frame_ram #(
        .DATA_W (`MLX_RAW_W)
    ) cal_ram_inst (
        .i_clk   (i_clk),
        .i_we    (i_cal_we),
        .i_waddr (i_cal_addr),
        .i_wdata (i_cal_data),
        .i_re    (i_pix_valid),
        .i_raddr (i_pix_addr),
        .o_rdata (cal_rd)
    );

    // delay the pixel to line up with the table read
    always_ff @(posedge i_clk) begin
        pix_addr_q <= i_pix_addr;
        pix_data_q <= i_pix_data;
        if (i_rst) begin
            pix_valid_q <= 1'b0;
        end else begin
            pix_valid_q <= i_pix_valid;
        end
    end

    // 15 bit offset sign extended to the pixel width
    assign offset    = {cal_rd[`MLX_RAW_W-2], cal_rd[`MLX_RAW_W-2:0]};
    assign dead      = cal_rd[`MLX_RAW_W-1];
    // wraps like the sensor arithmetic
    assign corrected = pix_data_q - offset;

    // ------------------------------------------------
    // registered subtraction and dead pixel fill
    // ------------------------------------------------
    always_ff @(posedge i_clk) begin
        o_corr_addr <= pix_addr_q;
        o_corr_data <= dead ? last_good : corrected;
        o_corr_dead <= dead;
        if (i_rst) begin
            o_corr_valid <= 1'b0;
            last_good    <= '0;
        end else begin
            o_corr_valid <= pix_valid_q;
            // only live pixels refresh the fill value
            if (pix_valid_q && !dead) begin
                last_good <= corrected;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/frame_stats.sv
`timescale 1ns/1ps
`default_nettype none

`include "mlx_defs.svh"

module frame_stats (
    input  logic                     i_clk,
    input  logic                     i_rst,
    // corrected pixel strobe
    input  logic                     i_corr_valid,
    input  mlx_pixel_pkg::pix_addr_t i_corr_addr,
    input  mlx_pixel_pkg::raw_pix_t  i_corr_data,
    input  logic                     i_corr_dead,
    // raw frame read port for the normalizer
    input  logic                     i_raw_rd_en,
    input  mlx_pixel_pkg::pix_addr_t i_raw_rd_addr,
    output mlx_pixel_pkg::raw_pix_t  o_raw_rd_data,
    // frame result
    output logic                     o_norm_start,
    output mlx_pixel_pkg::raw_pix_t  o_frame_min,
    output mlx_pixel_pkg::range_t    o_frame_range
);

    localparam mlx_pixel_pkg::pix_addr_t LAST_ADDR = (`MLX_PIXELS - 1);
    localparam mlx_pixel_pkg::raw_pix_t  RAW_HI    = {1'b0, {(`MLX_RAW_W-1){1'b1}}};
    localparam mlx_pixel_pkg::raw_pix_t  RAW_LO    = {1'b1, {(`MLX_RAW_W-1){1'b0}}};

    mlx_pixel_pkg::raw_pix_t min_q;
    mlx_pixel_pkg::raw_pix_t max_q;
    mlx_pixel_pkg::raw_pix_t base_min;
    mlx_pixel_pkg::raw_pix_t base_max;
    mlx_pixel_pkg::raw_pix_t new_min;
    mlx_pixel_pkg::raw_pix_t new_max;
    mlx_pixel_pkg::range_t   span;
    logic                    last_pix;

    // ------------------------------------------------
    // raw framebuffer
    // ------------------------------------------------
    frame_ram #(
        .DATA_W (`MLX_RAW_W)
    ) raw_ram_inst (
        .i_clk   (i_clk),
        .i_we    (i_corr_valid),
        .i_waddr (i_corr_addr),
        .i_wdata (i_corr_data),
        .i_re    (i_raw_rd_en),
        .i_raddr (i_raw_rd_addr),
        .o_rdata (o_raw_rd_data)
    );

    // ------------------------------------------------
    // running min and max
    // ------------------------------------------------
    always_comb begin
        // pixel 0 starts a new frame from the extremes
        base_min = (i_corr_addr == '0) ? RAW_HI : min_q;
        base_max = (i_corr_addr == '0) ? RAW_LO : max_q;
        new_min  = base_min;
        new_max  = base_max;
        // dead pixels carry a copied value and do not count
        if (!i_corr_dead) begin
            if (i_corr_data < base_min) begin
                new_min = i_corr_data;
            end
            if (i_corr_data > base_max) begin
                new_max = i_corr_data;
            end
        end
    end

    // 17 bit difference of sign extended values
    assign span     = {new_max[`MLX_RAW_W-1], new_max} - {new_min[`MLX_RAW_W-1], new_min};
    assign last_pix = i_corr_valid && (i_corr_addr == LAST_ADDR);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            min_q         <= RAW_HI;
            max_q         <= RAW_LO;
            o_frame_min   <= '0;
            o_frame_range <= mlx_pixel_pkg::range_t'(1);
            o_norm_start  <= 1'b0;
        end else begin
            o_norm_start <= last_pix;
            if (i_corr_valid) begin
                min_q <= new_min;
                max_q <= new_max;
            end
            if (last_pix) begin
                o_frame_min <= new_min;
                // flat frame or no live pixel gives range 1
                if (new_max > new_min) begin
                    o_frame_range <= span;
                end else begin
                    o_frame_range <= mlx_pixel_pkg::range_t'(1);
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/pixel_normalizer.sv
`timescale 1ns/1ps
`default_nettype none

`include "mlx_defs.svh"

module pixel_normalizer (
    input  logic                      i_clk,
    input  logic                      i_rst,
    input  logic                      i_start,
    input  mlx_pixel_pkg::raw_pix_t   i_min,
    input  mlx_pixel_pkg::range_t     i_range,
    // raw frame read
    output logic                      o_raw_rd_en,
    output mlx_pixel_pkg::pix_addr_t  o_raw_rd_addr,
    input  mlx_pixel_pkg::raw_pix_t   i_raw_rd_data,
    // display frame write
    output logic                      o_disp_we,
    output mlx_pixel_pkg::pix_addr_t  o_disp_addr,
    output mlx_pixel_pkg::norm_pix_t  o_disp_data,
    output logic                      o_busy,
    output logic                      o_frame_done
);

    // dividend is (value - min) * 255
    localparam int NUM_W  = `MLX_RANGE_W + `MLX_NORM_W;
    localparam int STEP_W = $clog2(`MLX_DIV_STEPS + 1);
    localparam mlx_pixel_pkg::pix_addr_t LAST_ADDR = (`MLX_PIXELS - 1);

    mlx_ctrl_pkg::norm_state_t state;
    mlx_pixel_pkg::pix_addr_t  addr;
    logic [STEP_W-1:0]         step;

    mlx_pixel_pkg::raw_pix_t   min_q;
    mlx_pixel_pkg::range_t     range_q;
    mlx_pixel_pkg::range_t     diff;
    logic [NUM_W-1:0]          num;
    logic [NUM_W-1:0]          rem;
    logic [NUM_W-1:0]          div;
    mlx_pixel_pkg::norm_pix_t  quo;
    logic                      take;

    // value >= min, so the sign extended difference fits unsigned
    assign diff = {i_raw_rd_data[`MLX_RAW_W-1], i_raw_rd_data} - {min_q[`MLX_RAW_W-1], min_q};
    assign num  = NUM_W'(diff) * NUM_W'(`MLX_NORM_MAX);
    assign take = (rem >= div);

    // ------------------------------------------------
    // control FSM
    // ------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state <= mlx_ctrl_pkg::IDLE;
            addr  <= '0;
            step  <= '0;
        end else begin
            case (state)
                mlx_ctrl_pkg::IDLE: begin
                    // a start while running is dropped
                    if (i_start) begin
                        addr  <= '0;
                        state <= mlx_ctrl_pkg::FETCH;
                    end
                end
                mlx_ctrl_pkg::FETCH: begin
                    step  <= '0;
                    state <= mlx_ctrl_pkg::DIVIDE;
                end
                mlx_ctrl_pkg::DIVIDE: begin
                    // step 0 loads, steps 1..8 make quotient bits
                    step <= step + 1'b1;
                    if (step == STEP_W'(`MLX_DIV_STEPS)) begin
                        state <= mlx_ctrl_pkg::STORE;
                    end
                end
                mlx_ctrl_pkg::STORE: begin
                    if (addr == LAST_ADDR) begin
                        state <= mlx_ctrl_pkg::IDLE;
                    end else begin
                        addr  <= addr + 1'b1;
                        state <= mlx_ctrl_pkg::FETCH;
                    end
                end
                default: begin
                    state <= mlx_ctrl_pkg::IDLE;
                end
            endcase
        end
    end

    // ------------------------------------------------
    // restoring divider
    // ------------------------------------------------
    always_ff @(posedge i_clk) begin
        // frame parameters held for the whole pass
        if (state == mlx_ctrl_pkg::IDLE && i_start) begin
            min_q   <= i_min;
            range_q <= i_range;
        end
        if (state == mlx_ctrl_pkg::DIVIDE) begin
            if (step == '0) begin
                rem <= num;
                // quotient < 256, so start at range << 7
                div <= NUM_W'(range_q) << (`MLX_DIV_STEPS - 1);
                quo <= '0;
            end else begin
                if (take) begin
                    rem <= rem - div;
                end
                div <= div >> 1;
                quo <= {quo[`MLX_NORM_W-2:0], take};
            end
        end
    end

    assign o_raw_rd_en   = (state == mlx_ctrl_pkg::FETCH);
    assign o_raw_rd_addr = addr;
    assign o_disp_we     = (state == mlx_ctrl_pkg::STORE);
    assign o_disp_addr   = addr;
    assign o_disp_data   = quo;
    assign o_busy        = (state != mlx_ctrl_pkg::IDLE);
    // done with the write of the last pixel
    assign o_frame_done  = (state == mlx_ctrl_pkg::STORE) && (addr == LAST_ADDR);

endmodule

`default_nettype wire

// File: hw/thermal_frame_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "mlx_defs.svh"

module thermal_frame_top (
    input  logic                      i_clk,
    input  logic                      i_rst,
    // calibration load
    input  logic                      i_cal_we,
    input  mlx_pixel_pkg::pix_addr_t  i_cal_addr,
    input  mlx_pixel_pkg::cal_word_t  i_cal_data,
    // raw pixels
    input  logic                      i_pix_valid,
    input  mlx_pixel_pkg::pix_addr_t  i_pix_addr,
    input  mlx_pixel_pkg::raw_pix_t   i_pix_data,
    // display read port
    input  logic                      i_fb_rd_en,
    input  mlx_pixel_pkg::pix_addr_t  i_fb_rd_addr,
    output mlx_pixel_pkg::norm_pix_t  o_fb_rd_data,
    output logic                      o_busy,
    output logic                      o_frame_done
);

    logic                     corr_valid;
    mlx_pixel_pkg::pix_addr_t corr_addr;
    mlx_pixel_pkg::raw_pix_t  corr_data;
    logic                     corr_dead;

    logic                     norm_start;
    mlx_pixel_pkg::raw_pix_t  frame_min;
    mlx_pixel_pkg::range_t    frame_range;

    logic                     raw_rd_en;
    mlx_pixel_pkg::pix_addr_t raw_rd_addr;
    mlx_pixel_pkg::raw_pix_t  raw_rd_data;

    logic                     disp_we;
    mlx_pixel_pkg::pix_addr_t disp_addr;
    mlx_pixel_pkg::norm_pix_t disp_data;

    // ------------------------------------------------
    // pixel path
    // ------------------------------------------------
    offset_correct offset_correct_inst (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_cal_we     (i_cal_we),
        .i_cal_addr   (i_cal_addr),
        .i_cal_data   (i_cal_data),
        .i_pix_valid  (i_pix_valid),
        .i_pix_addr   (i_pix_addr),
        .i_pix_data   (i_pix_data),
        .o_corr_valid (corr_valid),
        .o_corr_addr  (corr_addr),
        .o_corr_data  (corr_data),
        .o_corr_dead  (corr_dead)
    );

    frame_stats frame_stats_inst (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_corr_valid  (corr_valid),
        .i_corr_addr   (corr_addr),
        .i_corr_data   (corr_data),
        .i_corr_dead   (corr_dead),
        .i_raw_rd_en   (raw_rd_en),
        .i_raw_rd_addr (raw_rd_addr),
        .o_raw_rd_data (raw_rd_data),
        .o_norm_start  (norm_start),
        .o_frame_min   (frame_min),
        .o_frame_range (frame_range)
    );

    pixel_normalizer pixel_normalizer_inst (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_start       (norm_start),
        .i_min         (frame_min),
        .i_range       (frame_range),
        .o_raw_rd_en   (raw_rd_en),
        .o_raw_rd_addr (raw_rd_addr),
        .i_raw_rd_data (raw_rd_data),
        .o_disp_we     (disp_we),
        .o_disp_addr   (disp_addr),
        .o_disp_data   (disp_data),
        .o_busy        (o_busy),
        .o_frame_done  (o_frame_done)
    );

    // display framebuffer with its external read port
    frame_ram #(
        .DATA_W (`MLX_NORM_W)
    ) disp_ram_inst (
        .i_clk   (i_clk),
        .i_we    (disp_we),
        .i_waddr (disp_addr),
        .i_wdata (disp_data),
        .i_re    (i_fb_rd_en),
        .i_raddr (i_fb_rd_addr),
        .o_rdata (o_fb_rd_data)
    );

endmodule

`default_nettype wire

// File: verification/tb_frame_model.svh
`ifndef TB_FRAME_MODEL_SVH
`define TB_FRAME_MODEL_SVH

// ------------------------------------------------
// model state
// ------------------------------------------------
int unsigned              lcg_state = 75;
mlx_pixel_pkg::cal_word_t cal_table [`MLX_PIXELS];
mlx_pixel_pkg::raw_pix_t  raw_frame [`MLX_PIXELS];
int                       exp_disp  [`MLX_PIXELS];
// dead pixel fill value kept across frames like the pixel path
int                       model_last_good = 0;

// linear congruential generator returning its upper bits
function automatic int next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return int'(lcg_state >> 8);
endfunction

function automatic int rand_range(input int lo, input int hi);
    return lo + (next_rand() % (hi - lo + 1));
endfunction

// 15 bit signed offset in the low bits of a calibration word
function automatic int cal_offset(input mlx_pixel_pkg::cal_word_t w);
    int off;
    off = int'(w[`MLX_RAW_W-2:0]);
    if (off > 16383) begin
        off = off - 32768;
    end
    return off;
endfunction

// corrected values land in lo..hi with pixels 1 and 2 pinned to the ends
function automatic void make_frame(input int lo, input int hi);
    int p;
    int target;
    for (p = 0; p < `MLX_PIXELS; p++) begin
        target = rand_range(lo, hi);
        if (p == 1) begin
            target = lo;
        end
        if (p == 2) begin
            target = hi;
        end
        raw_frame[p] = mlx_pixel_pkg::raw_pix_t'(target + cal_offset(cal_table[p]));
    end
endfunction

// offset subtraction, dead fill, min and range, then scale to 0..255
function automatic void compute_expected();
    int p;
    int c;
    int mn;
    int mx;
    int range;
    int val [`MLX_PIXELS];
    mn = 32767;
    mx = -32768;
    for (p = 0; p < `MLX_PIXELS; p++) begin
        // 16 bit wraparound on the subtraction
        c = int'(shortint'(int'(raw_frame[p]) - cal_offset(cal_table[p])));
        if (cal_table[p][`MLX_RAW_W-1]) begin
            val[p] = model_last_good;
        end else begin
            val[p] = c;
            model_last_good = c;
            if (c < mn) begin
                mn = c;
            end
            if (c > mx) begin
                mx = c;
            end
        end
    end
    range = (mx > mn) ? (mx - mn) : 1;
    for (p = 0; p < `MLX_PIXELS; p++) begin
        exp_disp[p] = ((val[p] - mn) * `MLX_NORM_MAX) / range;
    end
endfunction

`endif

// File: verification/tb_thermal_frame.sv
`timescale 1ns/1ps
`default_nettype none

`include "mlx_defs.svh"

module tb_thermal_frame;

    localparam int NUM_FRAMES   = 4;
    localparam int FRAME_CYCLES = `MLX_PIXELS * 11 + 2000;

    logic                     i_clk;
    logic                     i_rst;
    logic                     i_cal_we;
    mlx_pixel_pkg::pix_addr_t i_cal_addr;
    mlx_pixel_pkg::cal_word_t i_cal_data;
    logic                     i_pix_valid;
    mlx_pixel_pkg::pix_addr_t i_pix_addr;
    mlx_pixel_pkg::raw_pix_t  i_pix_data;
    logic                     i_fb_rd_en;
    mlx_pixel_pkg::pix_addr_t i_fb_rd_addr;
    mlx_pixel_pkg::norm_pix_t o_fb_rd_data;
    logic                     o_busy;
    logic                     o_frame_done;

    int   done_count = 0;
    logic prev_done  = 1'b0;
    logic prev_busy  = 1'b0;

    `include "tb_frame_model.svh"

    thermal_frame_top thermal_frame_top_inst (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_cal_we     (i_cal_we),
        .i_cal_addr   (i_cal_addr),
        .i_cal_data   (i_cal_data),
        .i_pix_valid  (i_pix_valid),
        .i_pix_addr   (i_pix_addr),
        .i_pix_data   (i_pix_data),
        .i_fb_rd_en   (i_fb_rd_en),
        .i_fb_rd_addr (i_fb_rd_addr),
        .o_fb_rd_data (o_fb_rd_data),
        .o_busy       (o_busy),
        .o_frame_done (o_frame_done)
    );

    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    // normalizing dominates with some slack per frame for load and readback
    initial begin
        repeat (NUM_FRAMES * FRAME_CYCLES) @(posedge i_clk);
        abort_run("watchdog expired before all frames were checked");
    end

    // ------------------------------------------------
    // busy and done protocol monitor
    // ------------------------------------------------
    always @(negedge i_clk) begin
        if (!i_rst) begin
            assert (!(o_frame_done && prev_done))
                else abort_run("o_frame_done stayed high for more than one cycle");
            assert (!(prev_busy && !o_busy && !prev_done))
                else abort_run("o_busy dropped before o_frame_done");
            assert (!o_frame_done || o_busy)
                else abort_run("o_frame_done pulsed while o_busy was low");
            if (o_frame_done) begin
                done_count = done_count + 1;
            end
        end
        prev_done = o_frame_done;
        prev_busy = o_busy;
    end

    task automatic write_cal(input int first, input int last);
        int p;
        for (p = first; p <= last; p++) begin
            @(posedge i_clk);
            #1;
            i_cal_we   = 1'b1;
            i_cal_addr = mlx_pixel_pkg::pix_addr_t'(p);
            i_cal_data = cal_table[p];
        end
        @(posedge i_clk);
        #1;
        i_cal_we = 1'b0;
    endtask

    // one strobe per cycle with addresses in order
    task automatic send_frame();
        int p;
        for (p = 0; p < `MLX_PIXELS; p++) begin
            @(posedge i_clk);
            #1;
            i_pix_valid = 1'b1;
            i_pix_addr  = mlx_pixel_pkg::pix_addr_t'(p);
            i_pix_data  = raw_frame[p];
        end
        @(posedge i_clk);
        #1;
        i_pix_valid = 1'b0;
    endtask

    task automatic wait_frame_done(input int frames_sent);
        @(negedge i_clk);
        while (!o_frame_done) begin
            @(negedge i_clk);
        end
        @(posedge i_clk);
        #1;
        assert (!o_busy && !o_frame_done)
            else abort_run("o_busy or o_frame_done still high after the frame ended");
        assert (done_count == frames_sent)
            else abort_run("o_frame_done did not pulse once per frame");
    endtask

    // pipelined readback checking the previous address each cycle
    task automatic check_display();
        int p;
        int q;
        int got;
        for (p = 0; p <= `MLX_PIXELS; p++) begin
            @(posedge i_clk);
            #1;
            if (p > 0) begin
                q   = p - 1;
                got = int'(o_fb_rd_data);
                assert (got == exp_disp[q])
                    else abort_run($sformatf("Error o_fb_rd_data addr %h expected %h actual %h",
                                             q, exp_disp[q], got));
            end
            i_fb_rd_en   = (p < `MLX_PIXELS);
            i_fb_rd_addr = mlx_pixel_pkg::pix_addr_t'(p % `MLX_PIXELS);
        end
    endtask

    initial begin
        int p;
        int k;
        int dead_pix [5];
        dead_pix     = '{0, 5, 6, 300, 767};
        i_rst        = 1'b1;
        i_cal_we     = 1'b0;
        i_cal_addr   = '0;
        i_cal_data   = '0;
        i_pix_valid  = 1'b0;
        i_pix_addr   = '0;
        i_pix_data   = '0;
        i_fb_rd_en   = 1'b0;
        i_fb_rd_addr = '0;
        repeat (16) @(posedge i_clk);
        #1;
        i_rst = 1'b0;
        @(negedge i_clk);
        assert (!o_busy && !o_frame_done)
            else abort_run("o_busy or o_frame_done high after reset");

        // random offsets, all pixels live, wide spread
        for (p = 0; p < `MLX_PIXELS; p++) begin
            cal_table[p] = {1'b0, 15'(rand_range(-16384, 16383))};
        end
        write_cal(0, `MLX_PIXELS - 1);
        make_frame(-20000, 20000);
        send_frame();
        compute_expected();
        wait_frame_done(1);
        check_display();

        // dead pixels including pixel 0 and two with extreme raw words
        for (k = 0; k < 5; k++) begin
            cal_table[dead_pix[k]][`MLX_RAW_W-1] = 1'b1;
            write_cal(dead_pix[k], dead_pix[k]);
        end
        make_frame(-25000, 25000);
        raw_frame[5] = 16'sh7fff;
        raw_frame[6] = 16'sh8000;
        send_frame();
        compute_expected();
        wait_frame_done(2);
        check_display();

        // flat frame where range falls back to 1 and every pixel reads 0
        for (k = 0; k < 5; k++) begin
            cal_table[dead_pix[k]][`MLX_RAW_W-1] = 1'b0;
            write_cal(dead_pix[k], dead_pix[k]);
        end
        make_frame(1234, 1234);
        send_frame();
        compute_expected();
        wait_frame_done(3);
        check_display();

        // narrow spread so min and max must not carry over
        make_frame(-300, 500);
        send_frame();
        compute_expected();
        wait_frame_done(4);
        check_display();

        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+hw
+incdir+verification
hw/mlx_pixel_pkg.sv
hw/mlx_ctrl_pkg.sv
hw/frame_ram.sv
hw/offset_correct.sv
hw/frame_stats.sv
hw/pixel_normalizer.sv
hw/thermal_frame_top.sv
verification/tb_thermal_frame.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the thermal frame testbench with Verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f flist.f \
    --top-module tb_thermal_frame -Mdir obj_dir &&
./obj_dir/Vtb_thermal_frame ||
{ echo "simulation did not pass"; exit 1; }
